// ==== rtl/bch_pkg.sv ====
package bch_pkg;

	// code geometry for the binary BCH(15,7) double error correcting code
	localparam int gf_m   = 4;  // bits per field element of GF(2^4)
	localparam int code_n = 15; // codeword length, equal to 2^gf_m - 1
	localparam int code_k = 7;  // message bits in a systematic codeword

	// x^4 + x + 1 is primitive, so alpha = x generates all fifteen nonzero elements
	localparam logic [gf_m:0] gf_poly = 5'b10011;

	// g(x) = m1(x) * m3(x) = x^8 + x^7 + x^6 + x^4 + 1
	localparam logic [code_n-code_k:0] gen_poly = 9'h1d1;

	localparam logic [gf_m-1:0] gf_alpha  = 4'b0010; // alpha in polynomial basis
	localparam logic [gf_m-1:0] gf_alpha3 = 4'b1000; // alpha^3, the step for the S3 path

	// error counts run 0 to 2 and the all ones value flags an uncorrectable word
	localparam int cnt_w = 2;

	// shift and add multiply with reduction by gf_poly after every shift
	function automatic logic [gf_m-1:0] gf_mul(
		input logic [gf_m-1:0] a,
		input logic [gf_m-1:0] b
	);
		logic [gf_m-1:0] acc;   // running sum of partial products
		logic [gf_m-1:0] shift; // a times x^i, kept reduced
		acc   = '0;
		shift = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i]) begin
				acc = acc ^ shift; // add this partial product
			end
			if (shift[gf_m-1]) begin
				shift = (shift << 1) ^ gf_poly[gf_m-1:0]; // x^4 folds back to x + 1
			end else begin
				shift = shift << 1;
			end
		end
		return acc;
	endfunction

	// squaring is linear in characteristic two but a multiply keeps it compact
	function automatic logic [gf_m-1:0] gf_sq(
		input logic [gf_m-1:0] a
	);
		return gf_mul(a, a);
	endfunction

	// the cube is what a lone error at the same locator would give for S3
	function automatic logic [gf_m-1:0] gf_cube(
		input logic [gf_m-1:0] a
	);
		logic [gf_m-1:0] a2; // a squared
		a2 = gf_sq(a);
		return gf_mul(a2, a);
	endfunction

	/*
	 * error classes from the syndrome pair
	 *   S1 = 0 and S3 = 0      no error
	 *   S1 != 0, S3 = S1^3     one error
	 *   S1 != 0, S3 != S1^3    two errors
	 *   S1 = 0, S3 != 0        more than two errors
	 * a common scale factor b on S1 with b^3 on S3 leaves the class unchanged,
	 * which lets the Chien register carry normalized values
	 */

endpackage

// ==== rtl/bch_syndrome.sv ====
`timescale 1ns/1ns

module bch_syndrome (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      bit_valid, // an input bit is offered
	input  logic                      bit_in,    // received coefficient, highest power first
	input  logic                      dec_ready, // decoder can take a syndrome pair
	output logic                      ready,     // input side can accept a bit
	output logic                      start,     // hands s1 and s3 to the decoder
	output logic                      word_done, // fifteenth bit of a word is accepted
	output logic [bch_pkg::gf_m-1:0]  s1,        // r(alpha) of the held word
	output logic [bch_pkg::gf_m-1:0]  s3         // r(alpha^3) of the held word
);
	import bch_pkg::*;

	logic            take;       // a bit is accepted this cycle
	logic            restart;    // accepted bit is the first of a word
	logic [gf_m-1:0] pos;        // index of the next bit within the word
	logic [gf_m-1:0] acc1;       // partial S1 of the word being received
	logic [gf_m-1:0] acc3;       // partial S3 of the word being received
	logic [gf_m-1:0] prev1;      // partial S1 with the old word cleared away
	logic [gf_m-1:0] prev3;      // partial S3 with the old word cleared away
	logic [gf_m-1:0] nxt1;       // S1 after folding in the current bit
	logic [gf_m-1:0] nxt3;       // S3 after folding in the current bit
	logic            hold_full;  // s1 and s3 hold a pair not yet handed over

	assign take      = bit_valid & ready;
	assign restart   = (pos == '0);
	assign word_done = take & (pos == gf_m'(code_n - 1));

	// Horner step that starts from an empty accumulator on the first bit of a word
	assign prev1 = restart ? '0 : acc1;
	assign prev3 = restart ? '0 : acc3;
	assign nxt1  = gf_mul(prev1, gf_alpha) ^ {{(gf_m-1){1'b0}}, bit_in};
	assign nxt3  = gf_mul(prev3, gf_alpha3) ^ {{(gf_m-1){1'b0}}, bit_in};

	assign start = hold_full & dec_ready;   // pair leaves as soon as the decoder is idle
	assign ready = ~hold_full | start;      // stall the next word while a pair waits

	always_ff @(posedge clk) begin
		if (rst) begin
			pos       <= '0;
			hold_full <= 1'b0;
		end else begin
			if (take) begin
				pos <= word_done ? '0 : pos + 1'b1; // wrap after coefficient zero
			end
			if (word_done) begin
				hold_full <= 1'b1;
			end else if (start) begin
				hold_full <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			acc1 <= nxt1;
			acc3 <= nxt3;
		end
		if (word_done) begin
			s1 <= nxt1; // finished pair moves to the holding register
			s3 <= nxt3;
		end
	end

	// a pair goes out in one cycle because the decoder turns busy right after a load
	assert property (@(posedge clk) disable iff (rst) start |=> !start)
		else $error("bch_syndrome start lasted more than one cycle");

endmodule

// ==== rtl/bch_chien.sv ====
`timescale 1ns/1ns

module bch_chien (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     start,       // load a new syndrome pair
	input  logic [bch_pkg::gf_m-1:0] s1,
	input  logic [bch_pkg::gf_m-1:0] s3,
	output logic                     ready,       // idle and able to take start
	output logic                     count_cycle, // loaded values shown unstepped
	output logic                     first,       // testing coefficient 14
	output logic                     last,        // testing coefficient 0
	output logic                     valid,       // one position is tested this cycle
	output logic [bch_pkg::gf_m-1:0] ch1,         // S1 scaled to the tested position
	output logic [bch_pkg::gf_m-1:0] ch3          // S3 scaled to the tested position
);
	import bch_pkg::*;

	logic [gf_m-1:0] pos; // valid cycle count, zero at the first tested position

	// busy from the count cycle through the last tested position
	assign ready = ~(count_cycle | valid);
	assign first = valid & (pos == '0);
	assign last  = valid & (pos == gf_m'(code_n - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			count_cycle <= 1'b0;
			valid       <= 1'b0;
			pos         <= '0;
		end else begin
			count_cycle <= start; // one unstepped cycle follows every load
			if (count_cycle) begin
				valid <= 1'b1;
				pos   <= '0;
			end else if (valid) begin
				pos <= pos + 1'b1;
				if (last) begin
					valid <= 1'b0; // fifteen positions done
				end
			end
		end
	end

	/*
	 * multiplying by alpha equals dividing by alpha^14, so the loaded values
	 * are S1 and S3 normalized so that adding 1 tests coefficient 14
	 * each later step by alpha moves the test one coefficient lower
	 */
	always_ff @(posedge clk) begin
		if (start) begin
			ch1 <= gf_mul(s1, gf_alpha);
			ch3 <= gf_mul(s3, gf_alpha3);
		end else if (valid) begin
			ch1 <= gf_mul(ch1, gf_alpha);  // step to the next lower coefficient
			ch3 <= gf_mul(ch3, gf_alpha3); // cube of the same step
		end
	end

	// valid ends exactly fifteen cycles after it began
	assert property (@(posedge clk) disable iff (rst) $fell(valid) |-> $past(count_cycle, 16))
		else $error("bch_chien scan length is not fifteen");

endmodule

// ==== rtl/bch_error_dec.sv ====
`timescale 1ns/1ns

module bch_error_dec (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,     // new syndrome pair is presented
	input  logic [bch_pkg::gf_m-1:0]  s1,
	input  logic [bch_pkg::gf_m-1:0]  s3,
	output logic                      dec_ready, // idle and able to take start
	output logic                      first,     // first corrected bit of a word
	output logic                      last,      // last corrected bit of a word
	output logic                      valid,     // one bit position is tested
	output logic                      err,       // tested position is in error
	output logic [bch_pkg::cnt_w-1:0] err_count  // errors found in the current word
);
	import bch_pkg::*;

	logic             count_cycle; // Chien register shows the unflipped syndromes
	logic [gf_m-1:0]  ch1;         // normalized S1 from the Chien register
	logic [gf_m-1:0]  ch3;         // normalized S3 from the Chien register
	logic [gf_m-1:0]  ch1_flip;    // S1 with the tested bit flipped
	logic [gf_m-1:0]  ch3_flip;    // S3 with the tested bit flipped
	logic [gf_m-1:0]  ch1_cube;    // cube of the flipped S1
	logic [cnt_w-1:0] errors;      // error class of the flipped word
	logic [cnt_w-1:0] err_hits;    // positions flagged so far in this word

	bch_chien u_chien (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.s1         (s1),
		.s3         (s3),
		.ready      (dec_ready),
		.count_cycle(count_cycle),
		.first      (first),
		.last       (last),
		.valid      (valid),
		.ch1        (ch1),
		.ch3        (ch3)
	);

	// flipping the tested coefficient adds 1 to both normalized values
	assign ch1_flip = ch1 ^ {{(gf_m-1){1'b0}}, ~count_cycle};
	assign ch3_flip = ch3 ^ {{(gf_m-1){1'b0}}, ~count_cycle};
	assign ch1_cube = gf_cube(ch1_flip);

	always_comb begin
		if (ch1_flip != '0) begin
			// one error when S3 matches the cube of S1, otherwise two
			errors = (ch1_cube == ch3_flip) ? cnt_w'(1) : cnt_w'(2);
		end else if (ch3_flip != '0) begin
			errors = '1; // S1 cancels while S3 does not, which is beyond the code
		end else begin
			errors = '0;
		end
	end

	// a flip that lowers the count marks an error while uncorrectable words stay untouched
	assign err = valid & (err_count != '1) & (err_count > errors);

	always_ff @(posedge clk) begin
		if (rst) begin
			err_count <= '0;
			err_hits  <= '0;
		end else if (count_cycle) begin
			err_count <= errors; // unflipped class of the received word
			err_hits  <= '0;
		end else if (err) begin
			err_hits <= err_hits + 1'b1;
		end
	end

	// flags never outnumber the errors counted for the word
	assert property (@(posedge clk) disable iff (rst) err |-> err_hits < err_count)
		else $error("bch_error_dec more flags than the latched error count");

endmodule

// ==== rtl/bch_data_buffer.sv ====
`timescale 1ns/1ns

module bch_data_buffer (
	input  logic clk,
	input  logic rst,
	input  logic bit_valid_acc, // an input bit is accepted
	input  logic bit_in,        // the accepted bit
	input  logic word_done,     // accepted bit completes a word
	input  logic valid,         // decoder tests one position
	input  logic last,          // decoder tests the final position
	input  logic err,           // tested position is in error
	output logic out_valid,
	output logic out_bit,       // corrected bit, highest coefficient first
	output logic out_first,
	output logic out_last
);
	import bch_pkg::*;

	logic [code_n-1:0] mem [2]; // two word entries used in turn
	logic              wr_ptr;  // entry collecting incoming bits
	logic              rd_ptr;  // entry feeding the corrected output
	logic [1:0]        occ;     // entry holds a complete word awaiting output
	logic              reading; // inside a word after its first output bit

	assign out_valid = valid;
	assign out_first = valid & ~reading;
	assign out_last  = last;
	assign out_bit   = valid & (mem[rd_ptr][code_n-1] ^ err); // correction applied on the fly

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr  <= 1'b0;
			rd_ptr  <= 1'b0;
			occ     <= 2'b00;
			reading <= 1'b0;
		end else begin
			if (word_done) begin
				occ[wr_ptr] <= 1'b1;
				wr_ptr      <= ~wr_ptr; // next word goes to the other entry
			end
			if (valid && last) begin
				occ[rd_ptr] <= 1'b0; // entry free once its last bit is out
				rd_ptr      <= ~rd_ptr;
			end
			reading <= valid & ~last;
		end
	end

	// each entry shifts left for writing or for reading, never both at once
	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (bit_valid_acc && wr_ptr == 1'(i)) begin
				mem[i] <= {mem[i][code_n-2:0], bit_in};
			end else if (valid && rd_ptr == 1'(i)) begin
				mem[i] <= {mem[i][code_n-2:0], 1'b0};
			end
		end
	end

	// the input stall must keep a free entry for every completed word
	assert property (@(posedge clk) disable iff (rst) word_done |-> !(&occ))
		else $error("bch_data_buffer word completed with no free entry");

endmodule

// ==== rtl/bch_decoder_top.sv ====
`timescale 1ns/1ns

module bch_decoder_top (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      bit_valid, // a received bit is offered
	input  logic                      bit_in,    // received coefficient, highest power first
	output logic                      ready,     // decoder can accept a bit
	output logic                      out_valid, // a corrected bit is presented
	output logic                      out_bit,
	output logic                      out_first, // first bit of a corrected word
	output logic                      out_last,  // last bit of a corrected word
	output logic [bch_pkg::cnt_w-1:0] err_count, // errors in the word being output
	output logic                      err        // the current bit was flipped
);
	import bch_pkg::*;

	logic             bit_acc;    // bit taken this cycle
	logic             start;      // syndrome pair handed to the decoder
	logic             word_done;  // fifteenth bit of a word accepted
	logic             dec_ready;  // decoder idle
	logic [gf_m-1:0]  s1;
	logic [gf_m-1:0]  s3;
	logic             dec_first;
	logic             dec_last;
	logic             dec_valid;
	logic             dec_err;
	logic [cnt_w-1:0] dec_count;

	assign bit_acc   = bit_valid & ready;
	assign err       = dec_err;
	assign err_count = dec_count;

	bch_syndrome u_syndrome (
		.clk      (clk),
		.rst      (rst),
		.bit_valid(bit_valid),
		.bit_in   (bit_in),
		.dec_ready(dec_ready),
		.ready    (ready),
		.start    (start),
		.word_done(word_done),
		.s1       (s1),
		.s3       (s3)
	);

	bch_error_dec u_error_dec (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.s1       (s1),
		.s3       (s3),
		.dec_ready(dec_ready),
		.first    (dec_first),
		.last     (dec_last),
		.valid    (dec_valid),
		.err      (dec_err),
		.err_count(dec_count)
	);

	bch_data_buffer u_data_buffer (
		.clk          (clk),
		.rst          (rst),
		.bit_valid_acc(bit_acc),
		.bit_in       (bit_in),
		.word_done    (word_done),
		.valid        (dec_valid),
		.last         (dec_last),
		.err          (dec_err),
		.out_valid    (out_valid),
		.out_bit      (out_bit),
		.out_first    (out_first),
		.out_last     (out_last)
	);

	// the decoder's first is regenerated in the buffer and checked against it here
	assert property (@(posedge clk) disable iff (rst) out_first == dec_first)
		else $error("bch_decoder_top out_first disagrees with decoder");

endmodule

// ==== verif/bch_decoder_tb.sv ====
`timescale 1ns/1ns

module bch_decoder_tb;
	import bch_pkg::*;

	localparam int fixed_rows     = 12;
	localparam int random_rows    = 28;
	localparam int total_rows     = fixed_rows + random_rows;
	localparam int timeout_cycles = 20 * total_rows * code_n + 100; // 20 cycles per input bit

	// each row is {solid, message, error pattern}; a solid word and the next one have no idle cycles
	localparam logic [22:0] fixed_table [fixed_rows] = '{
		{1'b0, 7'h00, 15'h0000}, // all zero codeword
		{1'b0, 7'h5a, 15'h0000}, // clean word
		{1'b0, 7'h13, 15'h4000}, // one error on the first bit out
		{1'b0, 7'h7f, 15'h0001}, // one error on the last bit out
		{1'b1, 7'h2c, 15'h0100}, // opens a gapless run
		{1'b1, 7'h61, 15'h4001}, // two errors at both ends
		{1'b1, 7'h0e, 15'h0a00}, // two errors close together
		{1'b0, 7'h35, 15'h2010}, // closes the run
		{1'b0, 7'h48, 15'h0013}, // 1 + alpha + alpha^4 = 0 cancels S1 and leaves class 3
		{1'b1, 7'h77, 15'h7000}, // three adjacent errors
		{1'b1, 7'h19, 15'h0421},
		{1'b0, 7'h66, 15'h0248}
	};

	logic             clk;
	logic             rst;
	logic             bit_valid;
	logic             bit_in;
	logic             ready;
	logic             out_valid;
	logic             out_bit;
	logic             out_first;
	logic             out_last;
	logic             err;
	logic [cnt_w-1:0] err_count;

	logic [code_k-1:0] row_msg   [total_rows];
	logic [code_n-1:0] row_recv  [total_rows]; // codeword with the error pattern applied
	logic              row_solid [total_rows];
	logic [code_n-1:0] exp_word  [total_rows]; // expected corrected word
	logic [code_n-1:0] exp_err   [total_rows]; // expected err strobes with bit 14 coming out first
	logic [cnt_w-1:0]  exp_cnt   [total_rows];

	logic [31:0] lfsr_state;
	int          stall_cycles;    // offered bits held back by ready
	int          words_out;       // words fully seen on the output
	int          value_errors;
	int          protocol_errors;
	int          bit_idx;         // output bit within the current word
	int          bit_pos;         // coefficient that bit_idx maps to
	int          cycles = 0;
	logic        in_word;
	logic        reset_checked;

	bch_decoder_top dut (
		.clk      (clk),
		.rst      (rst),
		.bit_valid(bit_valid),
		.bit_in   (bit_in),
		.ready    (ready),
		.out_valid(out_valid),
		.out_bit  (out_bit),
		.out_first(out_first),
		.out_last (out_last),
		.err_count(err_count),
		.err      (err)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2 and 1
	endfunction

	// one LFSR step per bit taken with the new bit landing in bit 0
	task automatic draw(input int nbits, output int val);
		val = 0;
		for (int i = 0; i < nbits; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = (val << 1) | int'(lfsr_state[0]);
		end
	endtask

	// systematic encoder whose parity is the remainder of msg * x^8 divided by g(x)
	function automatic logic [code_n-1:0] encode(input logic [code_k-1:0] msg);
		logic [code_n-1:0] rem;
		rem = {msg, 8'h00};
		for (int i = code_n - 1; i >= code_n - code_k; i--) begin
			if (rem[i]) begin
				rem = rem ^ (code_n'(gen_poly) << (i - (code_n - code_k)));
			end
		end
		return {msg, rem[code_n-code_k-1:0]};
	endfunction

	// S1 = r(alpha) and S3 = r(alpha^3) summed term by term
	function automatic logic [2*gf_m-1:0] syndromes(input logic [code_n-1:0] word);
		logic [gf_m-1:0] s1;
		logic [gf_m-1:0] s3;
		logic [gf_m-1:0] p1; // alpha^j
		logic [gf_m-1:0] p3; // alpha^3j
		s1 = '0;
		s3 = '0;
		p1 = 4'b0001;
		p3 = 4'b0001;
		for (int j = 0; j < code_n; j++) begin
			if (word[j]) begin
				s1 = s1 ^ p1;
				s3 = s3 ^ p3;
			end
			p1 = gf_mul(p1, gf_alpha);
			p3 = gf_mul(p3, gf_alpha3);
		end
		return {s1, s3};
	endfunction

	function automatic logic [cnt_w-1:0] classify(input logic [2*gf_m-1:0] syn);
		logic [gf_m-1:0] s1;
		logic [gf_m-1:0] s3;
		s1 = syn[2*gf_m-1:gf_m];
		s3 = syn[gf_m-1:0];
		if (s1 != '0) begin
			return (gf_cube(s1) == s3) ? cnt_w'(1) : cnt_w'(2);
		end else if (s3 != '0) begin
			return cnt_w'(3); // beyond what the code corrects
		end
		return cnt_w'(0);
	endfunction

	// a position is flagged when flipping it gives a lower class than the word itself
	function automatic logic [code_n-1:0] flip_mask(input logic [code_n-1:0] recv);
		logic [cnt_w-1:0]  cnt;
		logic [cnt_w-1:0]  flipped;
		logic [code_n-1:0] mask;
		cnt  = classify(syndromes(recv));
		mask = '0;
		for (int j = 0; j < code_n; j++) begin
			flipped = classify(syndromes(recv ^ (code_n'(1) << j)));
			mask[j] = (cnt != cnt_w'(3)) && (cnt > flipped);
		end
		return mask;
	endfunction

	task automatic build_rows();
		logic [code_n-1:0] pat;
		int                v;
		int                weight;
		for (int r = 0; r < total_rows; r++) begin
			if (r < fixed_rows) begin
				{row_solid[r], row_msg[r], pat} = fixed_table[r];
			end else begin
				draw(code_k, v);
				row_msg[r] = v[code_k-1:0];
				draw(2, weight); // zero to three errors
				pat = '0;
				while ($countones(pat) < weight) begin
					draw(4, v);
					if (v < code_n) begin
						pat[v] = 1'b1;
					end
				end
				draw(1, v);
				row_solid[r] = v[0];
			end
			row_recv[r] = encode(row_msg[r]) ^ pat;
			weight = $countones(pat);
			if (weight <= 2) begin
				exp_err[r] = pat; // within reach of the code every error is found
				exp_cnt[r] = cnt_w'(weight);
			end else begin
				exp_err[r] = flip_mask(row_recv[r]);
				exp_cnt[r] = classify(syndromes(row_recv[r]));
			end
			exp_word[r] = row_recv[r] ^ exp_err[r];
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// ready depends on registers only, so its value here holds for the coming edge
	task automatic send_bit(input logic b);
		bit_valid = 1'b1;
		bit_in    = b;
		while (!ready) begin
			stall_cycles++;
			step();
		end
		step();
	endtask

	task automatic send_word(input int r);
		int v;
		for (int i = code_n - 1; i >= 0; i--) begin
			if (!row_solid[r]) begin
				draw(1, v);
				if (v != 0) begin
					bit_valid = 1'b0; // one idle cycle before this bit
					step();
				end
			end
			send_bit(row_recv[r][i]);
		end
		if (!row_solid[r]) begin
			draw(2, v);
			bit_valid = 1'b0;
			repeat (v) step();
		end
	endtask

	task automatic mismatch(input string sig, input int got, input int want);
		value_errors++;
		$display("[FAIL] %0t ns %s got %0h expected %0h", $time, sig, got, want);
	endtask

	task automatic fault(input string what);
		protocol_errors++;
		$display("protocol error at %0t ns: %s", $time, what);
	endtask

	// outputs settle after the rising edge, so the falling edge sees them stable
	always @(negedge clk) begin
		if (rst) begin
			in_word         = 1'b0;
			bit_idx         = 0;
			words_out       = 0;
			value_errors    = 0;
			protocol_errors = 0;
			reset_checked   = 1'b0;
		end else begin
			if (!reset_checked) begin
				assert (ready) else fault("ready is low right after reset");
				assert (!out_valid && !err && !out_first && !out_last)
					else fault("output strobes active right after reset");
				reset_checked = 1'b1;
			end
			if (out_valid) begin
				if (!in_word) begin
					assert (out_first) else fault("word started without out_first");
					assert (words_out < total_rows) else fault("more words out than were sent");
					in_word = 1'b1;
					bit_idx = 0;
				end else begin
					assert (!out_first) else fault("out_first repeated inside a word");
				end
				bit_pos = code_n - 1 - bit_idx; // MSB first in the order the bits arrived
				if (words_out < total_rows) begin
					assert (out_bit == exp_word[words_out][bit_pos])
						else mismatch("out_bit", int'(out_bit), int'(exp_word[words_out][bit_pos]));
					assert (err == exp_err[words_out][bit_pos])
						else mismatch("err", int'(err), int'(exp_err[words_out][bit_pos]));
					assert (err_count == exp_cnt[words_out])
						else mismatch("err_count", int'(err_count), int'(exp_cnt[words_out]));
				end
				assert (out_last == (bit_idx == code_n - 1))
					else mismatch("out_last", int'(out_last), int'(bit_idx == code_n - 1));
				if (bit_idx == code_n - 1) begin
					in_word = 1'b0;
					words_out++;
				end else begin
					bit_idx++;
				end
			end else begin
				assert (!in_word) else fault("out_valid dropped inside a word");
				assert (!out_first && !out_last && !err) else fault("strobe without out_valid");
			end
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout after %0d cycles, %0d of %0d words out", cycles, words_out,
				total_rows);
			$display("Regression failed");
			$finish;
		end
	end

	initial begin
		clk           = 1'b0;
		rst           = 1'b1;
		bit_valid     = 1'b0;
		bit_in        = 1'b0;
		lfsr_state    = 32'ha3fb_079c;
		stall_cycles  = 0;
		build_rows();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int r = 0; r < total_rows; r++) begin
			send_word(r);
		end
		bit_valid = 1'b0;
		wait (words_out == total_rows);
		step();
		// gapless rows must make a finished word wait for the busy decoder
		assert (stall_cycles > 0)
			else fault("input never stalled while back-to-back words were sent");
		$display("value errors %0d, protocol errors %0d, words %0d, input stalls %0d",
			value_errors, protocol_errors, words_out, stall_cycles);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
rtl/bch_pkg.sv
rtl/bch_syndrome.sv
rtl/bch_chien.sv
rtl/bch_error_dec.sv
rtl/bch_data_buffer.sv
rtl/bch_decoder_top.sv
verif/bch_decoder_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the BCH(15,7) decoder testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	-f compile.f --top-module bch_decoder_tb -o bch_sim

status=0
./obj_dir/bch_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
